// ==== Makefile ====
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= ifu_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST := tb.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/branch_predecode.sv ====
// Static branch predecoder
`timescale 1ns/1ps
`default_nettype none

module branch_predecode (
  input  wire ifu_pkg::instr_t rsp_instr,
  predict_if.source            pred
);

  logic       rv32;
  logic       is_jal;
  logic       is_bxx;
  logic       is_cj;
  logic       is_cb;
  logic       quad1;
  logic [2:0] c_funct3;

  ifu_pkg::pc_t imm_jal;
  ifu_pkg::pc_t imm_bxx;
  ifu_pkg::pc_t imm_cj;
  ifu_pkg::pc_t imm_cb;
  ifu_pkg::pc_t offset;

  ////////////////////////////////////////////////////////////////////////////
  // Length and class

  // Both low bits set marks a 32-bit encoding
  assign rv32 = &rsp_instr[1:0];

  assign is_jal = rv32 & (rsp_instr[6:0] == ifu_pkg::OPC_JAL);
  assign is_bxx = rv32 & (rsp_instr[6:0] == ifu_pkg::OPC_BRANCH);

  // Compressed jumps and branches all live in quadrant 1
  assign quad1    = ~rv32 & (rsp_instr[1:0] == ifu_pkg::RVC_QUAD1);
  assign c_funct3 = rsp_instr[15:13];

  // C.JAL exists on RV32 only, which is all we fetch
  assign is_cj = quad1 & ((c_funct3 == ifu_pkg::RVC_J) | (c_funct3 == ifu_pkg::RVC_JAL));
  assign is_cb = quad1 & ((c_funct3 == ifu_pkg::RVC_BEQZ) | (c_funct3 == ifu_pkg::RVC_BNEZ));

  ////////////////////////////////////////////////////////////////////////////
  // Immediates, all sign-extended with bit 0 zero

  // J-type, imm[20|10:1|11|19:12]
  assign imm_jal = {{12{rsp_instr[31]}}, rsp_instr[19:12], rsp_instr[20],
                    rsp_instr[30:21], 1'b0};

  // B-type, imm[12|10:5] and imm[4:1|11]
  assign imm_bxx = {{20{rsp_instr[31]}}, rsp_instr[7], rsp_instr[30:25],
                    rsp_instr[11:8], 1'b0};

  // CJ format, imm[11|4|9:8|10|6|7|3:1|5] in bits 12:2
  assign imm_cj = {{21{rsp_instr[12]}}, rsp_instr[8], rsp_instr[10:9],
                   rsp_instr[6], rsp_instr[7], rsp_instr[2], rsp_instr[11],
                   rsp_instr[5:3], 1'b0};

  // CB format, imm[8|4:3] in 12:10 and imm[7:6|2:1|5] in 6:2
  assign imm_cb = {{24{rsp_instr[12]}}, rsp_instr[6:5], rsp_instr[2],
                   rsp_instr[11:10], rsp_instr[4:3], 1'b0};

  // Only one class can match at a time
  always_comb begin
    if (is_jal) begin
      offset = imm_jal;
    end else if (is_bxx) begin
      offset = imm_bxx;
    end else if (is_cj) begin
      offset = imm_cj;
    end else if (is_cb) begin
      offset = imm_cb;
    end else begin
      offset = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Prediction

  assign pred.rv32   = rv32;
  assign pred.bjp    = is_jal | is_bxx | is_cj | is_cb;
  assign pred.offset = offset;

  // Jumps always taken
  // Backward branches taken, typical of loops
  assign pred.prdt_taken = is_jal | is_cj |
                           ((is_bxx | is_cb) & offset[ifu_pkg::PC_W-1]);

endmodule

`default_nettype wire

// ==== design/fetch_ctrl.sv ====
// Fetch handshake control
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            req_ready,
  input  wire logic            rsp_valid,
  input  wire logic            flush_req,
  input  wire logic            halt_req,
  input  wire logic            ir_accept,
  output logic                 req_valid,
  output logic                 rsp_ready,
  output logic                 halt_ack,
  output logic                 ir_load,
  output logic                 ir_flush,
  output logic                 pc_ena,
  output ifu_pkg::pc_src_t     pc_src
);

  logic       req_hsk;
  logic       rsp_hsk;
  logic       reset_req_r;
  logic       out_flag_r;
  logic       dly_flush_r;
  logic       halt_ack_r;
  logic       flush_real;
  logic       no_outs;
  logic       new_req;
  logic       new_req_condi;
  logic [1:0] outs_cnt_r;

  assign req_hsk = req_valid & req_ready;
  assign rsp_hsk = rsp_valid & rsp_ready;

  ////////////////////////////////////////////////////////////////////////////
  // State flags

  // Reset fetch pending until the first request goes out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reset_req_r <= 1'b1;
    end else if (req_hsk) begin
      reset_req_r <= 1'b0;
    end
  end

  // One request in flight at most
  // Set has priority
  // A new request can leave as the old response returns
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_flag_r <= 1'b0;
    end else if (req_hsk) begin
      out_flag_r <= 1'b1;
    end else if (rsp_hsk) begin
      out_flag_r <= 1'b0;
    end
  end

  // Flush is always taken
  // Remembered when no request leaves with it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dly_flush_r <= 1'b0;
    end else if (flush_req & ~req_hsk) begin
      dly_flush_r <= 1'b1;
    end else if (req_hsk) begin
      dly_flush_r <= 1'b0;
    end
  end

  // A returning response counts as nothing outstanding
  assign no_outs = ~out_flag_r | rsp_valid;

  // Halt ack follows the request once the bus is quiet
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt_ack_r <= 1'b0;
    end else if (halt_req & no_outs) begin
      halt_ack_r <= 1'b1;
    end else if (!halt_req) begin
      halt_ack_r <= 1'b0;
    end
  end

  assign halt_ack = halt_ack_r;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response channels

  assign flush_real    = flush_req | dly_flush_r;
  assign new_req       = ~halt_req;
  // Free slot or one that frees this cycle
  assign new_req_condi = ~out_flag_r | rsp_hsk;

  assign req_valid = (reset_req_r | flush_real | new_req) & new_req_condi;

  // Flushed responses are dropped so always take them
  // Otherwise wait for room in the IR and for the next request to go out
  // During halt the response waits so its successor address stays live
  assign rsp_ready = flush_real | (ir_accept & req_ready & ~halt_req);

  // Flush target takes priority over everything
  always_comb begin
    if (flush_req) begin
      pc_src = ifu_pkg::SRC_FLUSH;
    end else if (dly_flush_r) begin
      pc_src = ifu_pkg::SRC_DLY_FLUSH;
    end else if (reset_req_r) begin
      pc_src = ifu_pkg::SRC_RESET;
    end else begin
      pc_src = ifu_pkg::SRC_NEXT;
    end
  end

  // PC follows every issued request and every flush target
  assign pc_ena = req_hsk | flush_req;

  // IR control
  assign ir_load  = rsp_hsk & ~flush_real;
  assign ir_flush = flush_req;

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  // Requests minus responses, counted apart from the outstanding flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      outs_cnt_r <= '0;
    end else begin
      outs_cnt_r <= outs_cnt_r + {1'b0, req_hsk} - {1'b0, rsp_hsk};
    end
  end

  req_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(req_valid))
    else $error("req_valid is unknown");

  single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outs_cnt_r <= 2'd1)
    else $error("second request issued while one is outstanding");

endmodule

`default_nettype wire

// ==== design/ifu_fetch_top.sv ====
// Instruction fetch unit top
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_top (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire ifu_pkg::pc_t    pc_rtvec,
  // Request channel
  output logic                 ifu_req_valid,
  input  wire logic            ifu_req_ready,
  output ifu_pkg::pc_t         ifu_req_pc,
  output logic                 ifu_req_seq,
  // Response channel
  input  wire logic            ifu_rsp_valid,
  output logic                 ifu_rsp_ready,
  input  wire logic            ifu_rsp_err,
  input  wire ifu_pkg::instr_t ifu_rsp_instr,
  // IR channel to execute
  output logic                 ifu_ir_valid,
  input  wire logic            ifu_ir_ready,
  output ifu_pkg::instr_t      ifu_ir_instr,
  output ifu_pkg::pc_t         ifu_ir_pc,
  output logic                 ifu_ir_buserr,
  output logic                 ifu_ir_prdt_taken,
  // Flush and halt
  input  wire logic            ifu_flush_req,
  input  wire ifu_pkg::pc_t    ifu_flush_pc,
  input  wire logic            ifu_halt_req,
  output logic                 ifu_halt_ack
);

  ifu_pkg::pc_src_t pc_src;
  ifu_pkg::pc_t     pc;
  logic             pc_ena;
  logic             ir_load;
  logic             ir_flush;
  logic             ir_accept;

  // Predecode results of the instruction on the response channel
  predict_if pred_if_inst ();

  fetch_ctrl fetch_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_ready (ifu_req_ready),
    .rsp_valid (ifu_rsp_valid),
    .flush_req (ifu_flush_req),
    .halt_req  (ifu_halt_req),
    .ir_accept (ir_accept),
    .req_valid (ifu_req_valid),
    .rsp_ready (ifu_rsp_ready),
    .halt_ack  (ifu_halt_ack),
    .ir_load   (ir_load),
    .ir_flush  (ir_flush),
    .pc_ena    (pc_ena),
    .pc_src    (pc_src)
  );

  branch_predecode branch_predecode_inst (
    .rsp_instr (ifu_rsp_instr),
    .pred      (pred_if_inst.source)
  );

  pc_select pc_select_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc_ena   (pc_ena),
    .pc_src   (pc_src),
    .pc_rtvec (pc_rtvec),
    .flush_pc (ifu_flush_pc),
    .pred     (pred_if_inst.pc_sink),
    .req_pc   (ifu_req_pc),
    .pc       (pc),
    .req_seq  (ifu_req_seq)
  );

  ir_stage ir_stage_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ir_load       (ir_load),
    .ir_flush      (ir_flush),
    .rsp_err       (ifu_rsp_err),
    .rsp_instr     (ifu_rsp_instr),
    .pc            (pc),
    .pred          (pred_if_inst.ir_sink),
    .ir_ready      (ifu_ir_ready),
    .ir_valid      (ifu_ir_valid),
    .ir_accept     (ir_accept),
    .ir_buserr     (ifu_ir_buserr),
    .ir_prdt_taken (ifu_ir_prdt_taken),
    .ir_instr      (ifu_ir_instr),
    .ir_pc         (ifu_ir_pc)
  );

endmodule

`default_nettype wire

// ==== design/ifu_pkg.sv ====
// Fetch unit shared definitions
`default_nettype none

package ifu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths fixed by RV32C

  // Program counter width
  localparam int PC_W    = 32;
  // Fetched instruction width, compressed forms sit in the low half
  localparam int INSTR_W = 32;

  typedef logic [PC_W-1:0]    pc_t;
  typedef logic [INSTR_W-1:0] instr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode constants for the static predictor

  // Major opcodes of 32-bit jumps and branches
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Quadrant 1 compressed funct3 codes
  localparam logic [2:0] RVC_JAL    = 3'b001;
  localparam logic [2:0] RVC_J      = 3'b101;
  localparam logic [2:0] RVC_BEQZ   = 3'b110;
  localparam logic [2:0] RVC_BNEZ   = 3'b111;

  // Quadrant code of the compressed jumps and branches
  localparam logic [1:0] RVC_QUAD1  = 2'b01;

  ////////////////////////////////////////////////////////////////////////////
  // Next PC source

  typedef enum logic [1:0] {
    SRC_RESET     = 2'd0,  // Reset vector
    SRC_FLUSH     = 2'd1,  // Flush target from execute
    SRC_DLY_FLUSH = 2'd2,  // Remembered flush, target already in PC
    SRC_NEXT      = 2'd3   // Sequential or predicted
  } pc_src_t;

endpackage

`default_nettype wire

// ==== design/ir_stage.sv ====
// Instruction register toward execute
`timescale 1ns/1ps
`default_nettype none

module ir_stage (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            ir_load,
  input  wire logic            ir_flush,
  input  wire logic            rsp_err,
  input  wire ifu_pkg::instr_t rsp_instr,
  input  wire ifu_pkg::pc_t    pc,
  predict_if.ir_sink           pred,
  input  wire logic            ir_ready,
  output logic                 ir_valid,
  output logic                 ir_accept,
  output logic                 ir_buserr,
  output logic                 ir_prdt_taken,
  output ifu_pkg::instr_t      ir_instr,
  output ifu_pkg::pc_t         ir_pc
);

  localparam int HALF_W = ifu_pkg::INSTR_W / 2;

  logic              ir_valid_r;
  logic              ir_clr;
  logic [HALF_W-1:0] ir_hi_r;
  logic [HALF_W-1:0] ir_lo_r;
  ifu_pkg::pc_t      ir_pc_r;
  logic              ir_err_r;
  logic              ir_prdt_r;

  ////////////////////////////////////////////////////////////////////////////
  // Valid flag

  // Emptied by execute, or dropped by a flush
  assign ir_clr = ir_valid_r & (ir_ready | ir_flush);

  // Load wins over clear so a back-to-back refill keeps valid high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ir_valid_r <= 1'b0;
    end else if (ir_load) begin
      ir_valid_r <= 1'b1;
    end else if (ir_clr) begin
      ir_valid_r <= 1'b0;
    end
  end

  // Room for a new instruction this cycle
  assign ir_accept = ~ir_valid_r | ir_clr;

  ////////////////////////////////////////////////////////////////////////////
  // Payload

  // Upper half only toggles for 32-bit instructions, saves power
  always_ff @(posedge clk) begin
    if (ir_load & pred.rv32) begin
      ir_hi_r <= rsp_instr[ifu_pkg::INSTR_W-1:HALF_W];
    end
  end

  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir_lo_r   <= rsp_instr[HALF_W-1:0];
      ir_pc_r   <= pc;
      ir_err_r  <= rsp_err;
      ir_prdt_r <= pred.prdt_taken;
    end
  end

  assign ir_valid      = ir_valid_r;
  assign ir_instr      = {ir_hi_r, ir_lo_r};
  assign ir_pc         = ir_pc_r;
  assign ir_buserr     = ir_err_r;
  assign ir_prdt_taken = ir_prdt_r;

  // Relies on fetch_ctrl holding the response while execute stalls
  ir_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ir_valid_r && !ir_ready) |=>
      ($stable(ir_instr) && $stable(ir_pc) && $stable(ir_buserr) &&
       $stable(ir_prdt_taken)))
    else $error("IR contents changed while stalled");

endmodule

`default_nettype wire

// ==== design/pc_select.sv ====
// Next PC selection
`timescale 1ns/1ps
`default_nettype none

module pc_select (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             pc_ena,
  input  wire ifu_pkg::pc_src_t pc_src,
  input  wire ifu_pkg::pc_t     pc_rtvec,
  input  wire ifu_pkg::pc_t     flush_pc,
  predict_if.pc_sink            pred,
  output ifu_pkg::pc_t          req_pc,
  output ifu_pkg::pc_t          pc,
  output logic                  req_seq
);

  ifu_pkg::pc_t pc_r;
  ifu_pkg::pc_t add_op1;
  ifu_pkg::pc_t add_op2;
  ifu_pkg::pc_t pc_sum;
  ifu_pkg::pc_t incr;
  logic         bjp_taken;

  // Step by instruction length
  assign incr      = pred.rv32 ? ifu_pkg::pc_t'(4) : ifu_pkg::pc_t'(2);
  assign bjp_taken = pred.bjp & pred.prdt_taken;

  ////////////////////////////////////////////////////////////////////////////
  // Adder operands

  // One shared adder for every source
  always_comb begin
    add_op1 = pc_r;
    add_op2 = '0;
    req_seq = 1'b0;
    case (pc_src)
      ifu_pkg::SRC_RESET: begin
        add_op1 = pc_rtvec;
      end
      ifu_pkg::SRC_FLUSH: begin
        add_op1 = flush_pc;
      end
      ifu_pkg::SRC_DLY_FLUSH: begin
        // Target was loaded into the PC on the flush cycle
        add_op1 = pc_r;
      end
      default: begin
        if (bjp_taken) begin
          add_op2 = pred.offset;
        end else begin
          add_op2 = incr;
          req_seq = 1'b1;
        end
      end
    endcase
  end

  assign pc_sum = add_op1 + add_op2;

  // Halfword aligned always
  assign req_pc = {pc_sum[ifu_pkg::PC_W-1:1], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // PC register

  // Holds the address of the last issued request or flush target
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_r <= '0;
    end else if (pc_ena) begin
      pc_r <= req_pc;
    end
  end

  assign pc = pc_r;

  // Only a flush target may arrive odd
  // Every other source already sums to a halfword address
  pc_sum_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_src != ifu_pkg::SRC_FLUSH) |-> !pc_sum[0])
    else $error("odd next PC from a source other than flush");

endmodule

`default_nettype wire

// ==== design/predict_if.sv ====
// Predecode result bundle
`timescale 1ns/1ps
`default_nettype none

interface predict_if;

  // Instruction is 32 bits long
  logic rv32;
  // Jump or conditional branch
  logic bjp;
  // Static prediction says taken
  logic prdt_taken;
  // Sign-extended jump or branch offset
  ifu_pkg::pc_t offset;

  // Predecoder drives everything
  modport source (
    output rv32,
    output bjp,
    output prdt_taken,
    output offset
  );

  // Next PC logic needs length, class and target offset
  modport pc_sink (
    input rv32,
    input bjp,
    input prdt_taken,
    input offset
  );

  // IR keeps only the length and the prediction
  modport ir_sink (
    input rv32,
    input prdt_taken
  );

endinterface

`default_nettype wire

// ==== tb.f ====
design/ifu_pkg.sv
design/predict_if.sv
design/fetch_ctrl.sv
design/branch_predecode.sv
design/pc_select.sv
design/ir_stage.sv
design/ifu_fetch_top.sv
tb/ifu_tb.sv

// ==== tb/ifu_tb.sv ====
// Fetch unit testbench
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

  localparam ifu_pkg::pc_t RTVEC = 32'h8000_0000;

  // Test lengths in cycles
  localparam int LEN_RESET = 20;
  localparam int LEN_FREE  = 300;
  localparam int LEN_STALL = 400;
  localparam int LEN_FLUSH = 400;
  localparam int LEN_HALT  = 400;
  localparam int LEN_MIXED = 600;
  localparam int TIMEOUT_CYCLES =
    2 * (LEN_RESET + LEN_FREE + LEN_STALL + LEN_FLUSH + LEN_HALT + LEN_MIXED);

  logic clk;
  logic rst_n;
  logic ifu_req_ready;
  logic ifu_rsp_valid;
  logic ifu_rsp_err;
  logic ifu_ir_ready;
  logic ifu_flush_req;
  logic ifu_halt_req;
  ifu_pkg::pc_t ifu_flush_pc;
  ifu_pkg::instr_t ifu_rsp_instr;
  logic ifu_req_valid;
  logic ifu_req_seq;
  logic ifu_rsp_ready;
  logic ifu_ir_valid;
  logic ifu_ir_buserr;
  logic ifu_ir_prdt_taken;
  logic ifu_halt_ack;
  ifu_pkg::pc_t ifu_req_pc;
  ifu_pkg::pc_t ifu_ir_pc;
  ifu_pkg::instr_t ifu_ir_instr;

  // Program table with one entry per halfword address
  logic [31:0]  tab_instr [64];
  ifu_pkg::pc_t tab_off   [64];
  logic         tab_taken [64];
  logic         tab_rv32  [64];

  // Stimulus knobs
  logic gap_en;
  logic dly_en;
  logic flush_en;
  logic halt_en;

  // Memory responder state
  logic         mem_pend;
  ifu_pkg::pc_t mem_pc;
  logic [1:0]   mem_wait;

  // Reference model state
  logic         first_seen;
  logic         flush_pend;
  ifu_pkg::pc_t flush_tgt;
  logic [31:0]  q_instr [$];
  ifu_pkg::pc_t q_pc    [$];
  logic         q_err   [$];
  logic         q_taken [$];
  logic         q_rv32  [$];

  logic [15:0] lfsr_state;
  int errors;
  int n_req;
  int n_ir;
  int n_tests;
  int cycle_cnt;

  ifu_fetch_top ifu_fetch_top_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .pc_rtvec          (RTVEC),
    .ifu_req_valid     (ifu_req_valid),
    .ifu_req_ready     (ifu_req_ready),
    .ifu_req_pc        (ifu_req_pc),
    .ifu_req_seq       (ifu_req_seq),
    .ifu_rsp_valid     (ifu_rsp_valid),
    .ifu_rsp_ready     (ifu_rsp_ready),
    .ifu_rsp_err       (ifu_rsp_err),
    .ifu_rsp_instr     (ifu_rsp_instr),
    .ifu_ir_valid      (ifu_ir_valid),
    .ifu_ir_ready      (ifu_ir_ready),
    .ifu_ir_instr      (ifu_ir_instr),
    .ifu_ir_pc         (ifu_ir_pc),
    .ifu_ir_buserr     (ifu_ir_buserr),
    .ifu_ir_prdt_taken (ifu_ir_prdt_taken),
    .ifu_flush_req     (ifu_flush_req),
    .ifu_flush_pc      (ifu_flush_pc),
    .ifu_halt_req      (ifu_halt_req),
    .ifu_halt_ack      (ifu_halt_ack)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Galois LFSR stepped once per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // Kind 0 plain 32, 1 plain 16, 2 JAL, 3 C.J, 4 Bxx, 5 C.BEQZ
  function automatic logic [31:0] encode_instr(input logic [2:0] kind,
                                               input logic [31:0] off,
                                               input logic [15:0] fill);
    case (kind)
      3'd0: return {fill, fill[8:0], 7'b0010011};
      3'd1: return {fill, 3'b010, fill[10:0], 2'b00};
      3'd2: return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
      3'd3: return {fill, 3'b101, off[11], off[4], off[9:8], off[10], off[6],
                    off[7], off[3:1], off[5], 2'b01};
      3'd4: return {off[12], off[10:5], 5'd2, 5'd3, 3'b000, off[4:1], off[11],
                    7'b1100011};
      default: return {fill, 3'b110, off[8], off[4:3], 3'b001, off[7:6],
                       off[2:1], off[5], 2'b01};
    endcase
  endfunction

  task automatic note_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic build_table();
    logic [15:0] k;
    logic [15:0] r;
    logic [2:0]  kind;
    for (int i = 0; i < 64; i++) begin
      k = rand_bits(3);
      // Fold 6 and 7 onto the jump kinds
      kind = (k[2:0] >= 3'd6) ? (k[2:0] - 3'd4) : k[2:0];
      r = rand_bits(5);
      tab_off[i]   = {{27{r[4]}}, r[3:0], 1'b0};
      tab_instr[i] = encode_instr(kind, tab_off[i], rand_bits(16));
      tab_rv32[i]  = (kind == 3'd0) || (kind == 3'd2) || (kind == 3'd4);
      tab_taken[i] = (kind == 3'd2) || (kind == 3'd3) ||
                     (((kind == 3'd4) || (kind == 3'd5)) && r[4]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, reset and stimulus

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Memory responder and random handshake drivers
  always @(posedge clk) begin : drive_blk
    logic [15:0] r;
    if (!rst_n) begin
      ifu_req_ready <= 1'b1;
      ifu_ir_ready  <= 1'b1;
      ifu_rsp_valid <= 1'b0;
      ifu_flush_req <= 1'b0;
      ifu_halt_req  <= 1'b0;
      mem_pend      <= 1'b0;
    end else begin
      r = gap_en ? rand_bits(2) : 16'hffff;
      ifu_req_ready <= (r[1:0] != 2'b00);
      r = gap_en ? rand_bits(2) : 16'hffff;
      ifu_ir_ready <= (r[1:0] != 2'b00);
      if (ifu_rsp_valid && ifu_rsp_ready) begin
        ifu_rsp_valid <= 1'b0;
      end
      if (ifu_req_valid && ifu_req_ready) begin
        mem_pend <= 1'b1;
        mem_pc   <= ifu_req_pc;
        r = dly_en ? rand_bits(2) : 16'h0;
        mem_wait <= r[1:0];
      end else if (mem_pend) begin
        if (mem_wait == 2'd0) begin
          ifu_rsp_valid <= 1'b1;
          ifu_rsp_instr <= tab_instr[mem_pc[6:1]];
          ifu_rsp_err   <= mem_pc[5];
          mem_pend      <= 1'b0;
        end else begin
          mem_wait <= mem_wait - 2'd1;
        end
      end
      // Flush pulses with a target that may be odd
      r = flush_en ? rand_bits(4) : 16'hffff;
      ifu_flush_req <= (r[3:0] == 4'd0);
      if (flush_en) begin
        r = rand_bits(7);
        ifu_flush_pc <= RTVEC | {25'd0, r[6:0]};
      end
      // Halt held for random stretches
      r = halt_en ? rand_bits(4) : 16'hffff;
      if (!halt_en) begin
        ifu_halt_req <= 1'b0;
      end else if (ifu_halt_req) begin
        ifu_halt_req <= (r[2:0] != 3'd0);
      end else begin
        ifu_halt_req <= (r[3:0] == 4'd0);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks

  always @(posedge clk) begin : check_blk
    logic req_hsk;
    logic rsp_hsk;
    logic discard;
    logic [5:0] idx;
    ifu_pkg::pc_t exp_pc;
    logic exp_seq;
    logic [31:0] e_instr;
    logic e_rv32;
    if (rst_n) begin
      req_hsk = ifu_req_valid && ifu_req_ready;
      rsp_hsk = ifu_rsp_valid && ifu_rsp_ready;
      discard = ifu_flush_req || flush_pend;
      if (!first_seen) begin
        assert (!ifu_ir_valid && !ifu_halt_ack)
          else note_mismatch("IR valid or halt ack before first fetch");
      end
      // Halt blocks every request except a flush
      if (ifu_halt_req && ifu_req_valid) begin
        assert (ifu_flush_req || flush_pend)
          else note_mismatch("request raised during halt without flush");
      end
      // IR channel pops the oldest expected entry first
      if (ifu_ir_valid && ifu_ir_ready) begin
        if (q_pc.size() == 0) begin
          errors++;
          $display("error at %0t ns: IR handshake with no instruction expected", $time);
        end else begin
          e_instr = q_instr.pop_front();
          e_rv32  = q_rv32.pop_front();
          if (!e_rv32) begin
            e_instr[31:16] = ifu_ir_instr[31:16];
          end
          assert (ifu_ir_instr == e_instr)
            else note_mismatch($sformatf("IR instr %h, expected %h", ifu_ir_instr, e_instr));
          assert (ifu_ir_pc == q_pc[0])
            else note_mismatch($sformatf("IR pc %h, expected %h", ifu_ir_pc, q_pc[0]));
          assert (ifu_ir_buserr == q_err[0])
            else note_mismatch("IR bus error flag wrong");
          assert (ifu_ir_prdt_taken == q_taken[0])
            else note_mismatch("IR prediction flag wrong");
          void'(q_pc.pop_front());
          void'(q_err.pop_front());
          void'(q_taken.pop_front());
          n_ir++;
        end
      end else if (ifu_flush_req && ifu_ir_valid && q_pc.size() != 0) begin
        // Flushed out of the IR
        void'(q_instr.pop_front());
        void'(q_rv32.pop_front());
        void'(q_pc.pop_front());
        void'(q_err.pop_front());
        void'(q_taken.pop_front());
      end
      idx = mem_pc[6:1];
      if (rsp_hsk && !discard) begin
        q_instr.push_back(tab_instr[idx]);
        q_rv32.push_back(tab_rv32[idx]);
        q_pc.push_back(mem_pc);
        q_err.push_back(mem_pc[5]);
        q_taken.push_back(tab_taken[idx]);
      end
      // Expected request address
      if (req_hsk) begin
        exp_seq = 1'b0;
        exp_pc  = ifu_req_pc;
        if (!first_seen) begin
          exp_pc = RTVEC;
        end else if (ifu_flush_req) begin
          exp_pc = {ifu_flush_pc[31:1], 1'b0};
        end else if (flush_pend) begin
          exp_pc = flush_tgt;
        end else if (rsp_hsk) begin
          exp_seq = !tab_taken[idx];
          if (tab_taken[idx]) begin
            exp_pc = mem_pc + tab_off[idx];
          end else begin
            exp_pc = mem_pc + (tab_rv32[idx] ? 32'd4 : 32'd2);
          end
        end else begin
          errors++;
          $display("error at %0t ns: request issued while a fetch is outstanding", $time);
        end
        assert (ifu_req_pc == exp_pc)
          else note_mismatch($sformatf("req pc %h, expected %h", ifu_req_pc, exp_pc));
        assert (ifu_req_seq == exp_seq)
          else note_mismatch("req_seq flag wrong");
        first_seen = 1'b1;
        n_req++;
      end
      if (ifu_flush_req && !req_hsk) begin
        flush_pend = 1'b1;
        flush_tgt  = {ifu_flush_pc[31:1], 1'b0};
      end else if (req_hsk) begin
        flush_pend = 1'b0;
      end
    end
  end

  // Halt ack rises only once the bus is quiet
  halt_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ifu_halt_ack) |-> $past(ifu_halt_req && !mem_pend))
    else note_mismatch("halt ack rose with a fetch outstanding");

  halt_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
    !ifu_halt_req |=> !ifu_halt_ack)
    else note_mismatch("halt ack held after halt released");

  // Stalled IR holds its contents unless flushed
  ir_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ifu_ir_valid && !ifu_ir_ready && !ifu_flush_req) |=>
      (ifu_ir_valid && $stable(ifu_ir_instr) && $stable(ifu_ir_pc) &&
       $stable(ifu_ir_buserr) && $stable(ifu_ir_prdt_taken)))
    else note_mismatch("IR changed while stalled");

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence and run limit

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic run_test(input string name, input int cycles, input logic gaps,
                          input logic delays, input logic flushes, input logic halts);
    int req0;
    int ir0;
    int err0;
    @(negedge clk);
    gap_en   = gaps;
    dly_en   = delays;
    flush_en = flushes;
    halt_en  = halts;
    req0 = n_req;
    ir0  = n_ir;
    err0 = errors;
    repeat (cycles) @(negedge clk);
    if (n_req == req0) begin
      errors++;
      $display("error: no fetch request issued during test %s", name);
    end
    n_tests++;
    $display("test %-8s done: %0d requests, %0d IR words, %0d errors",
             name, n_req - req0, n_ir - ir0, errors - err0);
  endtask

  initial begin
    lfsr_state    = 16'd16896;
    rst_n         = 1'b0;
    ifu_req_ready = 1'b1;
    ifu_rsp_valid = 1'b0;
    ifu_rsp_err   = 1'b0;
    ifu_rsp_instr = '0;
    ifu_ir_ready  = 1'b1;
    ifu_flush_req = 1'b0;
    ifu_flush_pc  = RTVEC;
    ifu_halt_req  = 1'b0;
    gap_en = 1'b0;
    dly_en = 1'b0;
    flush_en = 1'b0;
    halt_en = 1'b0;
    mem_pend = 1'b0;
    mem_pc = '0;
    mem_wait = '0;
    first_seen = 1'b0;
    flush_pend = 1'b0;
    flush_tgt = '0;
    errors = 0;
    n_req = 0;
    n_ir = 0;
    n_tests = 0;
    cycle_cnt = 0;
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    run_test("reset", LEN_RESET, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("free", LEN_FREE, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("stall", LEN_STALL, 1'b1, 1'b1, 1'b0, 1'b0);
    run_test("flush", LEN_FLUSH, 1'b1, 1'b1, 1'b1, 1'b0);
    run_test("halt", LEN_HALT, 1'b1, 1'b1, 1'b0, 1'b1);
    run_test("mixed", LEN_MIXED, 1'b1, 1'b1, 1'b1, 1'b1);
    $display("summary: %0d tests, %0d requests, %0d IR words, %0d errors",
             n_tests, n_req, n_ir, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
